// File: hw/gba_mem_pkg.sv
/* regions decode from addr[27:24], bits 31:28 are ignored
   cartridge RAM is always writable, there is no backup-type config */
package gba_mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // request types
    //////////////////////////////////////////////////////////////////////

    // which CPU port owns a request
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        ROM      = 2'd1,
        RAM      = 2'd2,
        DMA_RSVD = 2'd3    // encoding kept, never driven
    } port_t;

    typedef struct packed {
        logic        en;      // instruction fetch valid
        logic [31:0] addr;    // word aligned (ARM) or half-word aligned (thumb)
        logic        thumb;   // 16-bit fetch
    } rom_req_t;

    typedef struct packed {
        logic        cen;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } ram_req_t;

    // single-cycle side, one request per cycle
    typedef struct packed {
        logic        rd;
        logic        wr;
        port_t       port;
        logic [27:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } bram_req_t;

    typedef struct packed {
        logic        rd;      // one-cycle strobe
        logic        wr;      // one-cycle strobe
        port_t       port;
        logic [23:0] addr;    // word address, byte addr bits 25:2
        logic [31:0] wdata;
        logic [3:0]  be;
    } sdram_req_t;

    //////////////////////////////////////////////////////////////////////
    // memory map
    //////////////////////////////////////////////////////////////////////

    localparam logic [3:0]  REG_EWRAM      = 4'h2;
    localparam logic [3:0]  REG_IWRAM      = 4'h3;
    localparam logic [3:0]  REG_ROM_FIRST  = 4'h8;   // game pak 8..C
    localparam logic [3:0]  REG_ROM_LAST   = 4'hc;
    localparam logic [3:0]  REG_CART_FIRST = 4'he;   // cart RAM mirrored in E and F
    localparam logic [3:0]  REG_CART_LAST  = 4'hf;

    localparam logic [23:0] SDRAM_EWRAM_BASE = 24'h80_0000;
    localparam logic [23:0] SDRAM_CART_BASE  = 24'h81_0000;
    localparam logic [31:0] POISON_WORD      = 32'hbaad_f00d;   // unmapped bram regions

    // regions served in one cycle by bram or poison
    function automatic logic is_single(input logic [3:0] region);
        case (region)
            4'h0, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hd: return 1'b1;
            default:                                 return 1'b0;
        endcase
    endfunction

    function automatic logic is_readonly(input logic [3:0] region);
        return (region == 4'h0) || (region inside {[REG_ROM_FIRST:REG_ROM_LAST]});
    endfunction

    // GBA byte address to SDRAM word address
    function automatic logic [23:0] to_sdram(input logic [27:0] addr);
        logic [3:0] region;
        region = addr[27:24];
        if (region inside {[REG_ROM_FIRST:REG_ROM_LAST]})
            return {1'b0, addr[24:2]};                       // 32MB rom at 0
        if (region == REG_EWRAM)
            return SDRAM_EWRAM_BASE + 24'(addr[17:2]);       // 256KB
        if (region inside {[REG_CART_FIRST:REG_CART_LAST]})
            return SDRAM_CART_BASE + 24'(addr[15:2]);        // 64KB
        return '1;
    endfunction

    // cart RAM sits on an 8-bit bus, so force the single addressed lane
    function automatic logic [3:0] sdram_be(input logic [27:0] addr, input logic [3:0] be);
        if (addr[27:24] inside {[REG_CART_FIRST:REG_CART_LAST]})
            return 4'b0001 << addr[1:0];
        return be;
    endfunction

endpackage

// File: hw/iwram_bank.sv
`timescale 1ns/1ns
/* IWRAM_WORDS should be a power of two, region 3 mirrors above that size
   read word is registered, valid the cycle after rd */
module iwram_bank #(
    parameter int IWRAM_WORDS = 8192
) (
    input  logic                   clk,
    input  gba_mem_pkg::bram_req_t bram_req,
    output logic [31:0]            iwram_rdata
);
    import gba_mem_pkg::*;

    localparam int AW = $clog2(IWRAM_WORDS);

    logic [31:0]   mem [IWRAM_WORDS];
    logic          sel;                 // request targets IWRAM
    logic [AW-1:0] word_addr;

    assign sel       = (bram_req.addr[27:24] == REG_IWRAM);
    assign word_addr = bram_req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (sel && bram_req.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (bram_req.be[i])     // byte lane write
                    mem[word_addr][8*i +: 8] <= bram_req.wdata[8*i +: 8];
            end
        end
        if (sel && bram_req.rd)
            iwram_rdata <= mem[word_addr];
    end

    a_write_has_lanes: assert property (@(posedge clk)
        (sel && bram_req.wr) |-> (bram_req.be != 4'b0000))
        else $error("IWRAM write with no byte enable");

endmodule

// File: hw/mem_sequencer.sv
`timescale 1ns/1ns
/* rom+ram double request runs ROM first, then RAM; SDRAM waits are unbounded
   sdram rd/wr are single-cycle strobes, addr and port stay put while waiting */
module mem_sequencer (
    input  logic                    clk,
    input  logic                    resetn,
    input  gba_mem_pkg::rom_req_t   rom_req,
    input  gba_mem_pkg::ram_req_t   ram_req,
    input  logic                    sdram_ready,
    output gba_mem_pkg::sdram_req_t sdram_req,
    output gba_mem_pkg::bram_req_t  bram_req,
    output logic                    cpu_en,
    output logic                    state_main,
    output logic                    double_req
);
    import gba_mem_pkg::*;

    typedef enum logic [2:0] {
        MAIN,        // idle, or comb logic drives the first request
        REQ1_WAIT,   // first request in sdram, wait for ready
        REQ2_BRAM,   // second (ram) request on bram
        REQ2_START,  // second request strobed to sdram
        REQ2_WAIT    // second request waits for ready
    } state_t;

    localparam bram_req_t  BRAM_IDLE  = '0;
    localparam sdram_req_t SDRAM_IDLE = '0;

    state_t     state;
    bram_req_t  bram_buf;                  // buffered second request
    sdram_req_t sdram_buf;                 // request in flight

    logic       rom_single, ram_single;    // served in one cycle
    logic       both;                      // double request
    logic       first_bram, first_sdram;   // where the first part goes
    logic       req1_done;                 // first part finishes this cycle
    bram_req_t  rom_bram, ram_bram;
    sdram_req_t rom_sdram, ram_sdram;

    //////////////////////////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////////////////////////

    assign rom_single  = is_single(rom_req.addr[27:24]);
    assign ram_single  = is_single(ram_req.addr[27:24]);
    assign both        = rom_req.en & ram_req.cen;
    // rom always wins the first slot
    assign first_bram  = rom_req.en ? rom_single : (ram_req.cen & ram_single);
    assign first_sdram = rom_req.en ? ~rom_single : (ram_req.cen & ~ram_single);
    assign req1_done   = (state == MAIN) ? first_bram : ((state == REQ1_WAIT) & sdram_ready);

    always_comb begin
        rom_bram       = BRAM_IDLE;     // fetch is always a full word read
        rom_bram.rd    = 1'b1;
        rom_bram.port  = ROM;
        rom_bram.addr  = rom_req.addr[27:0];
        rom_bram.be    = 4'b1111;

        ram_bram       = BRAM_IDLE;
        ram_bram.rd    = ~ram_req.wen;
        ram_bram.wr    = ram_req.wen;
        ram_bram.port  = RAM;
        ram_bram.addr  = ram_req.addr[27:0];
        ram_bram.wdata = ram_req.wdata;
        ram_bram.be    = ram_req.be;

        rom_sdram      = SDRAM_IDLE;
        rom_sdram.rd   = 1'b1;
        rom_sdram.port = ROM;
        rom_sdram.addr = to_sdram(rom_req.addr[27:0]);
        if (rom_req.thumb)
            rom_sdram.be = rom_req.addr[1] ? 4'b1100 : 4'b0011;   // upper or lower half
        else
            rom_sdram.be = 4'b1111;

        // writes to rom space turn into reads
        ram_sdram       = SDRAM_IDLE;
        ram_sdram.rd    = ~ram_req.wen | is_readonly(ram_req.addr[27:24]);
        ram_sdram.wr    = ram_req.wen & ~is_readonly(ram_req.addr[27:24]);
        ram_sdram.port  = RAM;
        ram_sdram.addr  = to_sdram(ram_req.addr[27:0]);
        ram_sdram.wdata = ram_req.wdata;
        ram_sdram.be    = sdram_be(ram_req.addr[27:0], ram_req.be);
    end

    //////////////////////////////////////////////////////////////////////
    // request outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bram_req     = BRAM_IDLE;
        sdram_req    = sdram_buf;    // keep addr and port while waiting
        sdram_req.rd = 1'b0;
        sdram_req.wr = 1'b0;
        case (state)
            MAIN: begin
                if (first_bram)
                    bram_req = rom_req.en ? rom_bram : ram_bram;
                if (first_sdram)
                    sdram_req = rom_req.en ? rom_sdram : ram_sdram;   // strobe in cycle 0
            end
            REQ2_BRAM:  bram_req  = bram_buf;
            REQ2_START: sdram_req = sdram_buf;
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= MAIN;
            double_req <= 1'b0;
        end else begin
            case (state)
                MAIN, REQ1_WAIT: begin
                    if (req1_done) begin
                        double_req <= both;
                        if (!both)
                            state <= MAIN;
                        else if (ram_single)
                            state <= REQ2_BRAM;
                        else
                            state <= REQ2_START;
                    end else if (state == MAIN && first_sdram) begin
                        state <= REQ1_WAIT;        // no start state, strobe went out already
                    end
                end
                REQ2_BRAM:  state <= MAIN;
                REQ2_START: state <= REQ2_WAIT;
                REQ2_WAIT: begin
                    if (sdram_ready)
                        state <= MAIN;
                end
                default:    state <= MAIN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MAIN && first_sdram)
            sdram_buf <= rom_req.en ? rom_sdram : ram_sdram;
        if (req1_done && both) begin       // park the ram part for later
            bram_buf <= ram_bram;
            if (!ram_single)
                sdram_buf <= ram_sdram;
        end
    end

    // ready for the whole access, rom-only/ram-only/double
    always_comb begin
        case ({rom_req.en, ram_req.cen})
            2'b00:   cpu_en = 1'b1;
            2'b10:   cpu_en = (state == MAIN) ? rom_single : sdram_ready;
            2'b01:   cpu_en = (state == MAIN) ? ram_single : sdram_ready;
            default: cpu_en = (state == REQ2_BRAM) | ((state == REQ2_WAIT) & sdram_ready);
        endcase
    end

    assign state_main = (state == MAIN);

    a_sdram_one_strobe: assert property (@(posedge clk) disable iff (!resetn)
        !(sdram_req.rd && sdram_req.wr))
        else $error("sdram rd and wr strobed together");

    a_req2_bram_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        (state == REQ2_BRAM) |=> (state == MAIN))
        else $error("REQ2_BRAM did not return to MAIN");

    a_bram_one_op: assert property (@(posedge clk) disable iff (!resetn)
        !(bram_req.rd && bram_req.wr))
        else $error("bram rd and wr together");

endmodule

// File: hw/cpu_rdata_hold.sv
`timescale 1ns/1ns
/* outputs update only in MAIN, the cycle after cpu_en; otherwise they hold
   sdram read data must hold per port until that port completes again */
module cpu_rdata_hold (
    input  logic                   clk,
    input  logic                   resetn,
    input  gba_mem_pkg::bram_req_t bram_req,
    input  logic [31:0]            iwram_rdata,
    input  logic [31:0]            sdram_rom_rdata,
    input  logic [31:0]            sdram_ram_rdata,
    input  logic                   rom_en,
    input  logic                   ram_cen,
    input  logic                   state_main,
    input  logic                   double_req,
    output logic [31:0]            rom_data,
    output logic [31:0]            ram_rdata
);
    import gba_mem_pkg::*;

    port_t       bram_port_r;       // last cycle's bram request
    logic        bram_rd_r;
    logic [3:0]  bram_region_r;
    logic        rom_en_r, ram_cen_r;
    logic        state_main_r;
    logic        rom_from_bram;     // rom part of the last access hit bram
    logic [31:0] bram_rdata;
    logic        rom_bram_hit, ram_bram_hit;
    logic [31:0] rom_rdata_new;     // rom word of a double, saved from bram
    logic [31:0] rom_rdata_buf, ram_rdata_buf;

    //////////////////////////////////////////////////////////////////////
    // bram read path
    //////////////////////////////////////////////////////////////////////

    assign bram_rdata   = (bram_region_r == REG_IWRAM) ? iwram_rdata : POISON_WORD;
    assign rom_bram_hit = bram_rd_r & (bram_port_r == ROM);
    assign ram_bram_hit = bram_rd_r & (bram_port_r == RAM);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bram_port_r   <= NONE;
            bram_rd_r     <= 1'b0;
            rom_en_r      <= 1'b0;
            ram_cen_r     <= 1'b0;
            state_main_r  <= 1'b1;
            rom_from_bram <= 1'b0;
        end else begin
            bram_port_r  <= bram_req.port;
            bram_rd_r    <= bram_req.rd;
            rom_en_r     <= rom_en;
            ram_cen_r    <= ram_cen;
            state_main_r <= state_main;
            if (state_main_r && rom_en_r)         // rom part was issued last cycle
                rom_from_bram <= rom_bram_hit;
        end
    end

    always_ff @(posedge clk) begin
        bram_region_r <= bram_req.addr[27:24];
        if (rom_bram_hit && double_req)           // ram part reuses bram next
            rom_rdata_new <= bram_rdata;
        rom_rdata_buf <= rom_data;
        ram_rdata_buf <= ram_rdata;
    end

    //////////////////////////////////////////////////////////////////////
    // CPU outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rom_data  = rom_rdata_buf;               // hold by default
        ram_rdata = ram_rdata_buf;
        if (state_main) begin
            if (rom_en_r) begin
                if (double_req)
                    rom_data = rom_from_bram ? rom_rdata_new : sdram_rom_rdata;
                else if (rom_bram_hit)
                    rom_data = bram_rdata;
                else
                    rom_data = sdram_rom_rdata;
            end
            if (ram_cen_r)
                ram_rdata = ram_bram_hit ? bram_rdata : sdram_ram_rdata;
        end
    end

endmodule

// File: hw/gba_mem_top.sv
`timescale 1ns/1ns
/* CPU holds rom_req/ram_req stable until it samples cpu_en high
   read data shows up the cycle after cpu_en and holds until the next access */
module gba_mem_top #(
    parameter int IWRAM_WORDS = 8192    // 32KB IWRAM
) (
    input  logic                    clk,
    input  logic                    resetn,

    // CPU side
    input  gba_mem_pkg::rom_req_t   rom_req,
    input  gba_mem_pkg::ram_req_t   ram_req,
    output logic [31:0]             rom_data,
    output logic [31:0]             ram_rdata,
    output logic                    cpu_en,       // access done, data valid next cycle

    // SDRAM side
    output gba_mem_pkg::sdram_req_t sdram_req,
    input  logic [31:0]             sdram_rom_rdata,
    input  logic [31:0]             sdram_ram_rdata,
    input  logic                    sdram_ready   // one-cycle pulse
);
    import gba_mem_pkg::*;

    bram_req_t   bram_req;       // single-cycle request, this cycle
    logic [31:0] iwram_rdata;    // registered, one cycle after read
    logic        state_main;
    logic        double_req;     // last access was rom+ram

    //////////////////////////////////////////////////////////////////////
    // request sequencing
    //////////////////////////////////////////////////////////////////////

    mem_sequencer u_seq (
        .clk         (clk),
        .resetn      (resetn),
        .rom_req     (rom_req),
        .ram_req     (ram_req),
        .sdram_ready (sdram_ready),
        .sdram_req   (sdram_req),
        .bram_req    (bram_req),
        .cpu_en      (cpu_en),
        .state_main  (state_main),
        .double_req  (double_req)
    );

    //////////////////////////////////////////////////////////////////////
    // read data back to the CPU
    //////////////////////////////////////////////////////////////////////

    cpu_rdata_hold u_hold (
        .clk             (clk),
        .resetn          (resetn),
        .bram_req        (bram_req),
        .iwram_rdata     (iwram_rdata),
        .sdram_rom_rdata (sdram_rom_rdata),
        .sdram_ram_rdata (sdram_ram_rdata),
        .rom_en          (rom_req.en),
        .ram_cen         (ram_req.cen),
        .state_main      (state_main),
        .double_req      (double_req),
        .rom_data        (rom_data),
        .ram_rdata       (ram_rdata)
    );

    iwram_bank #(
        .IWRAM_WORDS (IWRAM_WORDS)
    ) u_iwram (
        .clk         (clk),
        .bram_req    (bram_req),
        .iwram_rdata (iwram_rdata)
    );

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/1ns
/* free-running clock, resetn released on a falling edge after RESET_CYCLES */
module tb_clkgen #(
    parameter int HALF_PERIOD  = 20,   // 40 ns clock
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        resetn = 1'b0;                    // sync reset, held for whole cycles
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// File: verification/sdram_model.sv
`timescale 1ns/1ns
/* one access at a time, ready pulses LAT cycles after the strobe
   unwritten words read as addr ^ 32'h5a5a0000 */
module sdram_model #(
    parameter int LAT = 3
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  gba_mem_pkg::sdram_req_t sdram_req,
    output logic [31:0]             rom_rdata,
    output logic [31:0]             ram_rdata,
    output logic                    ready
);
    import gba_mem_pkg::*;

    logic [31:0] mem [logic [23:0]];    // sparse, only written words stored
    sdram_req_t  cur;                   // access in flight
    logic        busy;
    int          cnt;

    // stored word, or the preload pattern
    function automatic logic [31:0] peek(input logic [23:0] a);
        if (mem.exists(a))
            return mem[a];
        return {8'h00, a} ^ 32'h5a5a_0000;
    endfunction

    // old word with the enabled lanes replaced
    function automatic logic [31:0] merge_write(input logic [23:0] a, input logic [31:0] wdata,
                                                input logic [3:0] be);
        logic [31:0] w;
        w = peek(a);
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                w[8*i +: 8] = wdata[8*i +: 8];
        end
        return w;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            ready     <= 1'b0;
            cnt       <= 0;
            rom_rdata <= '0;
            ram_rdata <= '0;
        end else begin
            ready <= 1'b0;                       // single-cycle pulse
            if (sdram_req.rd || sdram_req.wr) begin
                cur  <= sdram_req;
                busy <= 1'b1;
                cnt  <= LAT;
                if (sdram_req.wr)                // write lands at strobe time
                    mem[sdram_req.addr] = merge_write(sdram_req.addr, sdram_req.wdata,
                                                      sdram_req.be);
            end else if (busy) begin
                cnt <= cnt - 1;
                if (cnt == 1) begin
                    ready <= 1'b1;
                    busy  <= 1'b0;
                    if (cur.rd && cur.port == ROM)
                        rom_rdata <= peek(cur.addr);  // holds until next rom read
                    if (cur.rd && cur.port == RAM)
                        ram_rdata <= peek(cur.addr);
                end
            end
        end
    end

endmodule

// File: verification/tb_gba_mem.sv
`timescale 1ns/1ns
/* table-driven CPU stimulus, inputs change on the falling edge
   expected words are worked out by hand from the address map and the sdram pattern */
module tb_gba_mem;
    import gba_mem_pkg::*;

    localparam int SDRAM_LAT = 3;
    localparam int TIMEOUT   = 100;     // cycles per wait

    typedef struct packed {
        rom_req_t    rom;
        ram_req_t    ram;
        logic [31:0] exp_rom;
        logic [31:0] exp_ram;
        logic        chk_rom;
        logic        chk_ram;
        logic        imm;               // cpu_en expected in request cycle
    } row_t;

    logic        clk, resetn;
    rom_req_t    rom_req;
    ram_req_t    ram_req;
    logic [31:0] rom_data, ram_rdata, sdram_rom_rdata, sdram_ram_rdata;
    logic        cpu_en, sdram_ready;
    sdram_req_t  sdram_req;

    row_t        rows[$];
    row_t        r;
    logic [31:0] last_rom, last_ram;    // values that must hold
    logic        rom_valid, ram_valid;
    int          waited, gap;

    tb_clkgen #(.HALF_PERIOD(20), .RESET_CYCLES(5)) u_clk (.clk(clk), .resetn(resetn));

    gba_mem_top #(.IWRAM_WORDS(8192)) dut (
        .clk(clk), .resetn(resetn), .rom_req(rom_req), .ram_req(ram_req),
        .rom_data(rom_data), .ram_rdata(ram_rdata), .cpu_en(cpu_en),
        .sdram_req(sdram_req), .sdram_rom_rdata(sdram_rom_rdata),
        .sdram_ram_rdata(sdram_ram_rdata), .sdram_ready(sdram_ready)
    );

    sdram_model #(.LAT(SDRAM_LAT)) u_sdram (
        .clk(clk), .resetn(resetn), .sdram_req(sdram_req),
        .rom_rdata(sdram_rom_rdata), .ram_rdata(sdram_ram_rdata), .ready(sdram_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic rom_req_t fetch(input logic [31:0] addr, input logic thumb);
        return '{en: 1'b1, addr: addr, thumb: thumb};
    endfunction

    function automatic ram_req_t data_op(input logic wen, input logic [31:0] addr,
                                         input logic [31:0] wdata, input logic [3:0] be);
        return '{cen: 1'b1, wen: wen, addr: addr, wdata: wdata, be: be};
    endfunction

    task automatic push_row(input rom_req_t rom, input ram_req_t ram,
                            input logic [31:0] er, input logic [31:0] ea,
                            input logic cr, input logic ca, input logic imm);
        row_t t;
        t = '{rom: rom, ram: ram, exp_rom: er, exp_ram: ea,
              chk_rom: cr, chk_ram: ca, imm: imm};
        rows.push_back(t);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // held values stay put while nothing new completed
    task automatic check_hold();
        if (rom_valid)
            assert (rom_data == last_rom) else abort_run($sformatf(
                "[ERROR] %0t rom_data moved to %h, held %h", $time, rom_data, last_rom));
        if (ram_valid)
            assert (ram_rdata == last_ram) else abort_run($sformatf(
                "[ERROR] %0t ram_rdata moved to %h, held %h", $time, ram_rdata, last_ram));
    endtask

    // a thumb fetch enables just the two lanes of its half-word, arm all four
    always @(posedge clk) begin
        if (resetn && sdram_req.rd && sdram_req.port == ROM) begin
            if (r.rom.thumb) begin
                assert ($countones(sdram_req.be) == 2
                        && sdram_req.be[{r.rom.addr[1], 1'b0} +: 2] == 2'b11)
                    else abort_run($sformatf("[ERROR] %0t thumb fetch be %b, addr %h",
                                             $time, sdram_req.be, r.rom.addr));
            end else begin
                assert (sdram_req.be == 4'b1111)
                    else abort_run($sformatf("[ERROR] %0t arm fetch be %b, addr %h",
                                             $time, sdram_req.be, r.rom.addr));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    initial begin
        // iwram full write, partial merge, read back
        push_row('0, data_op(1, 32'h0300_0010, 32'h1122_3344, 4'b1111), 0, 0, 0, 0, 1);
        push_row('0, data_op(1, 32'h0300_0010, 32'haabb_ccdd, 4'b0101), 0, 0, 0, 0, 1);
        push_row('0, data_op(0, 32'h0300_0010, 0, 4'b1111), 0, 32'h11bb_33dd, 0, 1, 1);
        push_row('0, data_op(0, 32'h0500_0000, 0, 4'b1111), 0, 32'hbaad_f00d, 0, 1, 1);
        // rom fetches, arm and thumb, regions 8 and c
        push_row(fetch(32'h0800_0100, 0), '0, 32'h5a5a_0040, 0, 1, 0, 0);
        push_row(fetch(32'h0c00_0202, 1), '0, 32'h5a5a_0080, 0, 1, 0, 0);
        push_row(fetch(32'h0800_0106, 1), '0, 32'h5a5a_0041, 0, 1, 0, 0);
        // ewram at sdram 0x800008
        push_row('0, data_op(1, 32'h0200_0020, 32'h1234_5678, 4'b0011), 0, 0, 0, 0, 0);
        push_row('0, data_op(0, 32'h0200_0020, 0, 4'b1111), 0, 32'h5ada_5678, 0, 1, 0);
        // write to rom turns into a read
        push_row('0, data_op(1, 32'h0800_0100, 32'hffff_ffff, 4'b1111),
                 0, 32'h5a5a_0040, 0, 1, 0);
        push_row('0, data_op(0, 32'h0800_0100, 0, 4'b1111), 0, 32'h5a5a_0040, 0, 1, 0);
        // cart ram, only lane 1 of word 0x810001 changes
        push_row('0, data_op(1, 32'h0e00_0005, 32'ha1b2_c3d4, 4'b1111), 0, 0, 0, 0, 0);
        push_row('0, data_op(0, 32'h0e00_0004, 0, 4'b1111), 0, 32'h5adb_c301, 0, 1, 0);
        // double requests
        push_row(fetch(32'h0300_0010, 0), data_op(0, 32'h0200_0020, 0, 4'b1111),
                 32'h11bb_33dd, 32'h5ada_5678, 1, 1, 0);
        push_row(fetch(32'h0800_0100, 0), data_op(0, 32'h0e00_0004, 0, 4'b1111),
                 32'h5a5a_0040, 32'h5adb_c301, 1, 1, 0);
        push_row(fetch(32'h0c00_0202, 1), data_op(0, 32'h0300_0010, 0, 4'b1111),
                 32'h5a5a_0080, 32'h11bb_33dd, 1, 1, 0);
    end

    //////////////////////////////////////////////////////////////////////
    // main loop
    //////////////////////////////////////////////////////////////////////

    initial begin
        rom_req   = '0;
        ram_req   = '0;
        rom_valid = 1'b0;
        ram_valid = 1'b0;
        waited    = $urandom(25);       // seed once
        waited    = 0;
        while (resetn !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 20)
                abort_run("reset was never released");
        end

        foreach (rows[i]) begin
            r   = rows[i];
            gap = $urandom % 4;         // idle cycles, outputs must hold
            repeat (gap) begin
                @(negedge clk);
                #1;
                check_hold();
            end

            @(negedge clk);
            rom_req = r.rom;
            ram_req = r.ram;
            waited  = 0;
            #1;
            while (!cpu_en) begin
                if (waited == TIMEOUT)
                    abort_run($sformatf("row %0d hung, cpu_en never came", i));
                @(negedge clk);
                #1;
                waited++;
            end
            assert (!r.imm || waited == 0) else abort_run($sformatf(
                "[ERROR] %0t row %0d cpu_en late by %0d cycles", $time, i, waited));

            @(negedge clk);             // data cycle after cpu_en
            rom_req = '0;
            ram_req = '0;
            #1;
            if (r.rom.en && r.chk_rom) begin
                assert (rom_data == r.exp_rom) else abort_run($sformatf(
                    "[ERROR] %0t row %0d rom_data %h, expected %h",
                    $time, i, rom_data, r.exp_rom));
                last_rom  = r.exp_rom;
                rom_valid = 1'b1;
            end else if (rom_valid) begin
                assert (rom_data == last_rom) else abort_run($sformatf(
                    "[ERROR] %0t row %0d rom_data moved to %h", $time, i, rom_data));
            end
            if (r.ram.cen && r.chk_ram) begin
                assert (ram_rdata == r.exp_ram) else abort_run($sformatf(
                    "[ERROR] %0t row %0d ram_rdata %h, expected %h",
                    $time, i, ram_rdata, r.exp_ram));
                last_ram  = r.exp_ram;
                ram_valid = 1'b1;
            end else if (r.ram.cen) begin
                ram_valid = 1'b0;       // write, read data undefined
            end else if (ram_valid) begin
                assert (ram_rdata == last_ram) else abort_run($sformatf(
                    "[ERROR] %0t row %0d ram_rdata moved to %h", $time, i, ram_rdata));
            end
        end

        repeat (2) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: flist.f
hw/gba_mem_pkg.sv
hw/iwram_bank.sv
hw/mem_sequencer.sv
hw/cpu_rdata_hold.sv
hw/gba_mem_top.sv
verification/tb_clkgen.sv
verification/sdram_model.sv
verification/tb_gba_mem.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench, exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_gba_mem \
    --Mdir obj_dir -o tb_gba_mem \
    && ./obj_dir/tb_gba_mem \
    || exit 1
